//--- design/adc_bus_pkg.sv
// Bus address layout, command codes and identification constant
package adc_bus_pkg;

  // Parallel bus widths
  localparam int addr_width = 19;
  localparam int data_width = 16;

  // --------------------
  // Address fields
  // --------------------
  // Command nibble at the bottom of the address
  localparam int cmd_lsb = 0;
  localparam int cmd_msb = 3;
  // Channel select nibble
  localparam int chan_lsb = 4;
  localparam int chan_msb = 7;
  // Block offset, bit 8 up to the top address bit
  localparam int offset_lsb = 8;

  // --------------------
  // Command codes
  // --------------------
  localparam logic [3:0] cmd_overflow = 4'h1;
  localparam logic [3:0] cmd_divide   = 4'h2;
  localparam logic [3:0] cmd_program  = 4'h4;
  localparam logic [3:0] cmd_sample   = 4'h7;
  localparam logic [3:0] cmd_sequence = 4'h8;
  localparam logic [3:0] cmd_id       = 4'h9;
  localparam logic [3:0] cmd_busy     = 4'hA;

  // Fixed word returned by an ID read
  localparam logic [15:0] id_value = 16'h0ADC;

endpackage

//--- design/adc_frame_pkg.sv
// Serial frame width, received channel field and program flag bit
package adc_frame_pkg;

  // --------------------
  // Serial frame
  // --------------------
  // One frame is 16 serial clock periods long
  localparam int frame_width = 16;

  // Received frames carry their channel number in the top bits,
  // from this bit up to frame_width-1
  localparam int frame_chan_lsb = 13;

  // --------------------
  // Program word
  // --------------------
  // Set in a program word when it should be shifted out to the chip
  localparam int program_flag_bit = 15;

endpackage

//--- design/adc_bus_regs.sv
// Bus decode, program word, divide value and per-channel overflow registers
`timescale 1ns/1ns

module adc_bus_regs #(
  parameter int position     = 0,
  parameter int num_channels = 8
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [adc_bus_pkg::addr_width-1:0]   addr,
  input  logic [adc_bus_pkg::data_width-1:0]   data_in,
  input  logic                                 enable,
  input  logic                                 re,
  input  logic                                 wr,
  input  logic                                 busy,
  input  logic                                 program_taken,
  output logic [adc_bus_pkg::data_width-1:0]   program_word,
  output logic                                 program_pending,
  output logic [adc_bus_pkg::data_width-1:0]   divide_value,
  output logic [num_channels*adc_bus_pkg::data_width-1:0] overflow_values,
  output logic                                 read_strobe,
  output logic [adc_bus_pkg::cmd_msb-adc_bus_pkg::cmd_lsb:0]   read_cmd,
  output logic [adc_bus_pkg::chan_msb-adc_bus_pkg::chan_lsb:0] read_chan
);

  logic offset_match;
  logic hit;
  logic program_write;
  logic overflow_write;
  logic divide_write;

  // --------------------
  // Decode
  // --------------------
  // Block selected only when the offset field equals our position
  assign offset_match = (int'(addr[adc_bus_pkg::addr_width-1:adc_bus_pkg::offset_lsb])
                         == position);
  assign hit = enable && offset_match;

  // Command and channel go straight on to the read side
  assign read_cmd    = addr[adc_bus_pkg::cmd_msb:adc_bus_pkg::cmd_lsb];
  assign read_chan   = addr[adc_bus_pkg::chan_msb:adc_bus_pkg::chan_lsb];
  assign read_strobe = hit && re;

  // Write strobes per command
  // Program word is locked while the engine runs a frame
  assign program_write  = hit && wr && !busy && (read_cmd == adc_bus_pkg::cmd_program);
  assign overflow_write = hit && wr && (read_cmd == adc_bus_pkg::cmd_overflow);
  assign divide_write   = hit && wr && (read_cmd == adc_bus_pkg::cmd_divide);

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      program_word    <= '0;
      program_pending <= 1'b0;
      divide_value    <= '0;
      overflow_values <= '0;
    end else begin
      if (program_write) begin
        program_word <= data_in;
      end
      // A fresh write beats the engine taking the old word
      if (program_write) begin
        program_pending <= data_in[adc_frame_pkg::program_flag_bit];
      end else if (program_taken) begin
        program_pending <= 1'b0;
      end
      if (divide_write) begin
        divide_value <= data_in;
      end
      // Channels past num_channels are simply not stored
      for (int i = 0; i < num_channels; i++) begin
        if (overflow_write && (int'(read_chan) == i)) begin
          overflow_values[i*adc_bus_pkg::data_width +: adc_bus_pkg::data_width] <= data_in;
        end
      end
    end
  end

  // Engine may only take a program word that this block marked pending
  assert property (@(posedge clk) disable iff (reset) program_taken |-> program_pending)
    else $error("program word taken with nothing pending");

endmodule

//--- design/adc_serial_engine.sv
// Serial clock divider, frame FSM, program shift-out and result shift-in
`timescale 1ns/1ns

module adc_serial_engine (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [adc_bus_pkg::data_width-1:0]    divide_value,
  input  logic [adc_frame_pkg::frame_width-1:0] program_word,
  input  logic                                  program_pending,
  input  logic                                  adc_dout,
  output logic                                  program_taken,
  output logic                                  busy,
  output logic                                  frame_valid,
  output logic [adc_frame_pkg::frame_width-1:0] frame_data,
  output logic                                  cs,
  output logic                                  adc_sclk,
  output logic                                  adc_din
);

  localparam int fw = adc_frame_pkg::frame_width;

  // FSM encoding
  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_program = 2'd1;
  localparam logic [1:0] st_receive = 2'd2;
  localparam logic [1:0] st_deliver = 2'd3;

  logic [adc_bus_pkg::data_width-1:0] tick_cnt;
  logic                               tick;
  logic [1:0]                         state;
  logic [3:0]                         bit_cnt;
  logic [fw-1:0]                      shift_out;
  logic [fw-1:0]                      shift_in;
  logic                               in_frame;
  logic                               sclk_rise;
  logic                               sclk_fall;
  logic [4:0]                         sclk_periods;

  // --------------------
  // Half period ticks
  // --------------------
  // Free running, one tick every divide_value+1 cycles
  // >= so a smaller divide written mid-count still ticks
  assign tick = (tick_cnt >= divide_value);

  always_ff @(posedge clk) begin
    if (reset || tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  assign in_frame  = (state == st_program) || (state == st_receive);
  assign sclk_rise = tick && in_frame && !adc_sclk;
  assign sclk_fall = tick && in_frame && adc_sclk;

  assign busy       = (state != st_idle);
  assign adc_din    = shift_out[fw-1];
  assign frame_data = shift_in;
  // Taken in the same cycle the program frame starts
  assign program_taken = (state == st_idle) && tick && program_pending;

  // --------------------
  // Frame FSM
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= st_idle;
      cs          <= 1'b1;
      adc_sclk    <= 1'b0;
      bit_cnt     <= '0;
      shift_out   <= '0;
      shift_in    <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= 1'b0;
      case (state)
        // Idle half period with cs high, then pick the frame type
        st_idle: begin
          if (tick) begin
            cs      <= 1'b0;
            bit_cnt <= '0;
            if (program_pending) begin
              state     <= st_program;
              shift_out <= program_word;
            end else begin
              state <= st_receive;
            end
          end
        end
        st_program, st_receive: begin
          if (sclk_rise) begin
            adc_sclk <= 1'b1;
            // Chip output is stable around our rising edge
            if (state == st_receive) begin
              shift_in <= {shift_in[fw-2:0], adc_dout};
            end
          end else if (sclk_fall) begin
            adc_sclk <= 1'b0;
            // Next program bit after each falling edge, MSB first
            shift_out <= {shift_out[fw-2:0], 1'b0};
            bit_cnt   <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd15) begin
              cs    <= 1'b1;
              state <= (state == st_receive) ? st_deliver : st_idle;
            end
          end
        end
        // One cycle to hand the result frame on
        st_deliver: begin
          frame_valid <= 1'b1;
          state       <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // --------------------
  // Frame length check
  // --------------------
  // Serial periods seen while cs is low
  always_ff @(posedge clk) begin
    if (reset || cs) begin
      sclk_periods <= '0;
    end else if (sclk_rise) begin
      sclk_periods <= sclk_periods + 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (reset) $rose(cs) |-> (sclk_periods == 5'd16))
    else $error("cs low for %0d serial periods", sclk_periods);

  // Result handed on once in the cycle after cs rises
  assert property (@(posedge clk) disable iff (reset)
                   frame_valid |-> $past(cs) && !$past(cs, 2))
    else $error("frame_valid not a single pulse right after cs rises");

endmodule

//--- design/adc_channel_hold.sv
// Per-channel latest frame, rate counters, sample and sequence registers
`timescale 1ns/1ns

module adc_channel_hold #(
  parameter int num_channels = 8
) (
  input  logic                                               clk,
  input  logic                                               reset,
  input  logic                                               frame_valid,
  input  logic [adc_frame_pkg::frame_width-1:0]              frame_data,
  input  logic [num_channels*adc_bus_pkg::data_width-1:0]    overflow_values,
  output logic [num_channels*adc_frame_pkg::frame_width-1:0] sample_values,
  output logic [num_channels*adc_bus_pkg::data_width-1:0]    sequence_values
);

  localparam int fw = adc_frame_pkg::frame_width;
  localparam int dw = adc_bus_pkg::data_width;

  // Channel number carried in the top bits of each frame
  logic [fw-1-adc_frame_pkg::frame_chan_lsb:0] frame_chan;

  assign frame_chan = frame_data[fw-1:adc_frame_pkg::frame_chan_lsb];

  // --------------------
  // One slot per channel
  // --------------------
  for (genvar c = 0; c < num_channels; c++) begin : g_chan
    logic [fw-1:0] latest;
    logic [dw-1:0] rate_cnt;
    logic [dw-1:0] overflow;
    logic [fw-1:0] sample;
    logic [dw-1:0] seq_num;

    assign overflow = overflow_values[c*dw +: dw];

    always_ff @(posedge clk) begin
      if (reset) begin
        latest   <= '0;
        rate_cnt <= '0;
        sample   <= '0;
        seq_num  <= '0;
      end else begin
        // Newer frame overwrites an unpublished one
        if (frame_valid && (int'(frame_chan) == c)) begin
          latest <= frame_data;
        end
        // Publish every overflow+1 cycles
        if (rate_cnt == overflow) begin
          rate_cnt <= '0;
          sample   <= latest;
          seq_num  <= seq_num + 1'b1;
        end else begin
          rate_cnt <= rate_cnt + 1'b1;
        end
      end
    end

    assign sample_values[c*fw +: fw]   = sample;
    assign sequence_values[c*dw +: dw] = seq_num;
  end

endmodule

//--- design/adc_readback.sv
// Registered read multiplexer for samples, sequence numbers, ID and busy
`timescale 1ns/1ns

module adc_readback #(
  parameter int num_channels = 8
) (
  input  logic                                               clk,
  input  logic                                               reset,
  input  logic                                               read_strobe,
  input  logic [adc_bus_pkg::cmd_msb-adc_bus_pkg::cmd_lsb:0]   read_cmd,
  input  logic [adc_bus_pkg::chan_msb-adc_bus_pkg::chan_lsb:0] read_chan,
  input  logic [num_channels*adc_frame_pkg::frame_width-1:0] sample_values,
  input  logic [num_channels*adc_bus_pkg::data_width-1:0]    sequence_values,
  input  logic                                               busy,
  output logic [adc_bus_pkg::data_width-1:0]                 data_out
);

  localparam int fw = adc_frame_pkg::frame_width;
  localparam int dw = adc_bus_pkg::data_width;

  logic chan_ok;

  // Channels we do not have read as zero
  assign chan_ok = (int'(read_chan) < num_channels);

  // --------------------
  // Read register
  // --------------------
  // Zero on every cycle without a read
  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= '0;
    end else begin
      data_out <= '0;
      if (read_strobe) begin
        case (read_cmd)
          adc_bus_pkg::cmd_sample:   if (chan_ok) data_out <= sample_values[read_chan*fw +: fw];
          adc_bus_pkg::cmd_sequence: if (chan_ok) data_out <= sequence_values[read_chan*dw +: dw];
          adc_bus_pkg::cmd_id:       data_out <= adc_bus_pkg::id_value;
          adc_bus_pkg::cmd_busy:     data_out <= {{(dw-1){1'b0}}, busy};
          default:                   data_out <= '0;
        endcase
      end
    end
  end

endmodule

//--- design/adc_control.sv
// ADC controller top level with bus registers, serial engine, channel hold and readback
`timescale 1ns/1ns

module adc_control #(
  parameter int position     = 0,
  parameter int num_channels = 8
) (
  input  logic                               clk,
  input  logic                               reset,
  // Parallel bus
  input  logic [adc_bus_pkg::addr_width-1:0] addr,
  input  logic [adc_bus_pkg::data_width-1:0] data_in,
  input  logic                               enable,
  input  logic                               re,
  input  logic                               wr,
  output logic [adc_bus_pkg::data_width-1:0] data_out,
  // Serial ADC
  output logic                               cs,
  output logic                               adc_sclk,
  output logic                               adc_din,
  input  logic                               adc_dout
);

  localparam int dw = adc_bus_pkg::data_width;
  localparam int fw = adc_frame_pkg::frame_width;

  // Bus side to engine
  logic [dw-1:0] program_word;
  logic          program_pending;
  logic [dw-1:0] divide_value;
  logic          program_taken;
  logic          busy;
  // Engine to channel hold
  logic          frame_valid;
  logic [fw-1:0] frame_data;
  // Rates in, published values out
  logic [num_channels*dw-1:0] overflow_values;
  logic [num_channels*fw-1:0] sample_values;
  logic [num_channels*dw-1:0] sequence_values;
  // Read request
  logic                                                 read_strobe;
  logic [adc_bus_pkg::cmd_msb-adc_bus_pkg::cmd_lsb:0]   read_cmd;
  logic [adc_bus_pkg::chan_msb-adc_bus_pkg::chan_lsb:0] read_chan;

  // --------------------
  // Blocks
  // --------------------
  adc_bus_regs #(.position(position), .num_channels(num_channels)) u_bus_regs (
    .clk, .reset, .addr, .data_in, .enable, .re, .wr, .busy, .program_taken,
    .program_word, .program_pending, .divide_value, .overflow_values,
    .read_strobe, .read_cmd, .read_chan
  );

  adc_serial_engine u_engine (
    .clk, .reset, .divide_value, .program_word, .program_pending, .adc_dout,
    .program_taken, .busy, .frame_valid, .frame_data, .cs, .adc_sclk, .adc_din
  );

  adc_channel_hold #(.num_channels(num_channels)) u_channel_hold (
    .clk, .reset, .frame_valid, .frame_data, .overflow_values,
    .sample_values, .sequence_values
  );

  adc_readback #(.num_channels(num_channels)) u_readback (
    .clk, .reset, .read_strobe, .read_cmd, .read_chan,
    .sample_values, .sequence_values, .busy, .data_out
  );

endmodule

//--- verification/adc_chip_model.sv
// Behavioral serial ADC that answers read frames and records program words
`timescale 1ns/1ns

module adc_chip_model (
  input  logic        cs,
  input  logic        adc_sclk,
  input  logic        adc_din,
  input  logic [15:0] reply_word,
  output logic        adc_dout,
  output logic [2:0]  next_chan,
  output int          frame_count,
  output int          program_count,
  output logic [15:0] last_program,
  output int          half_period_ns
);

  logic [15:0] tx;
  logic [15:0] rx;
  logic        active;
  time         rise_time;

  initial begin
    adc_dout       = 1'b0;
    next_chan      = '0;
    frame_count    = 0;
    program_count  = 0;
    last_program   = '0;
    half_period_ns = 0;
    tx             = '0;
    rx             = '0;
    active         = 1'b0;
    rise_time      = 0;
  end

  // Frame start, reply for the current channel goes out MSB first
  always @(negedge cs) begin
    active   = 1'b1;
    tx       = reply_word;
    adc_dout = tx[15];
  end

  // Controller data is stable at our rising edge
  always @(posedge adc_sclk) begin
    if (active) begin
      rx        = {rx[14:0], adc_din};
      rise_time = $time;
    end
  end

  // High half just ended, so measure it and present the next bit
  always @(negedge adc_sclk) begin
    if (active) begin
      half_period_ns = int'($time - rise_time);
      tx             = {tx[14:0], 1'b0};
      adc_dout       = tx[15];
    end
  end

  // --------------------
  // End of frame
  // --------------------
  // Flag bit set means the controller sent a program word
  always @(posedge cs) begin
    if (active) begin
      active      = 1'b0;
      frame_count = frame_count + 1;
      if (rx[15]) begin
        last_program  = rx;
        program_count = program_count + 1;
      end else begin
        next_chan = next_chan + 1'b1;
      end
    end
  end

endmodule

//--- verification/adc_control_tb.sv
// Testbench for the ADC controller with clock, reset, LFSR, reference frames, checks and timeout
`timescale 1ns/1ns

module adc_control_tb;

  localparam int position     = 5;
  localparam int clk_period   = 40;
  localparam int reset_cycles = 16;
  localparam int div_a        = 3;
  localparam int div_b        = 6;
  localparam int seq_chan     = 2;
  localparam int seq_steps    = 3;
  // Overflow of channel c is 20+3c
  localparam int seq_gap      = seq_steps * (20 + 3 * seq_chan + 1);
  // Worst frame: idle wait, 32 halves, idle half, deliver cycle
  localparam int frame_a      = 35 * (div_a + 1) + 2;
  localparam int frame_b      = 35 * (div_b + 1) + 2;
  localparam int cycle_limit  = reset_cycles + 32 * frame_a + seq_gap + 3 * frame_b + 1000;

  logic                               clk;
  logic                               reset;
  logic [adc_bus_pkg::addr_width-1:0] addr;
  logic [adc_bus_pkg::data_width-1:0] data_in;
  logic                               enable;
  logic                               re;
  logic                               wr;
  logic [adc_bus_pkg::data_width-1:0] data_out;
  logic                               cs;
  logic                               adc_sclk;
  logic                               adc_din;
  logic                               adc_dout;
  // Chip model side
  logic [15:0] reply_word;
  logic [2:0]  next_chan;
  logic [15:0] last_program;
  int          frame_count;
  int          program_count;
  int          half_period_ns;

  logic [31:0] lfsr_state;
  int          cycles = 0;
  int          checks;
  int          errors;
  int          test_errors;

  adc_control #(.position(position), .num_channels(8)) uut (
    .clk, .reset, .addr, .data_in, .enable, .re, .wr, .data_out,
    .cs, .adc_sclk, .adc_din, .adc_dout
  );

  adc_chip_model chip (
    .cs, .adc_sclk, .adc_din, .reply_word, .adc_dout, .next_chan,
    .frame_count, .program_count, .last_program, .half_period_ns
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  // --------------------
  // LFSR and reference
  // --------------------
  // Galois form, taps x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [15:0] random_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v          = {v[14:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Channel in bits 15..13, below it 13 LFSR bits fixed per channel
  function automatic logic [15:0] expected_frame(input logic [2:0] chan);
    logic [31:0] s;
    logic [12:0] low;
    s   = 32'h3ae9;
    low = '0;
    for (int i = 0; i < 13 * int'(chan); i++) begin
      s = lfsr_next(s);
    end
    for (int i = 0; i < 13; i++) begin
      s   = lfsr_next(s);
      low = {low[11:0], s[0]};
    end
    return {chan, low};
  endfunction

  assign reply_word = expected_frame(next_chan);

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, a wait on the DUT never ended", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  // --------------------
  // Bus and check tasks
  // --------------------
  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic end_test(input string name);
    $display("Test %s finished with %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  function automatic logic [18:0] make_addr(input int offset, input logic [3:0] chan,
                                            input logic [3:0] cmd);
    return {offset[10:0], chan, cmd};
  endfunction

  task automatic bus_write(input logic [3:0] cmd, input logic [3:0] chan,
                           input logic [15:0] value);
    @(posedge clk);
    #2;
    addr    = make_addr(position, chan, cmd);
    data_in = value;
    enable  = 1'b1;
    wr      = 1'b1;
    @(posedge clk);
    #2;
    enable = 1'b0;
    wr     = 1'b0;
  endtask

  // data_out is registered on the edge after the strobe
  task automatic bus_read(input int offset, input logic [3:0] cmd, input logic [3:0] chan,
                          output logic [15:0] value);
    @(posedge clk);
    #2;
    addr   = make_addr(offset, chan, cmd);
    enable = 1'b1;
    re     = 1'b1;
    @(posedge clk);
    #2;
    enable = 1'b0;
    re     = 1'b0;
    value  = data_out;
  endtask

  task automatic wait_cs(input logic level);
    do begin
      @(posedge clk);
      #2;
    end while (cs !== level);
  endtask

  task automatic wait_frames(input int n);
    int target;
    target = frame_count + n;
    while (frame_count < target) begin
      @(posedge clk);
    end
  endtask

  // --------------------
  // Tests
  // --------------------
  initial begin
    logic [15:0] value;
    logic [15:0] first_word;
    logic [15:0] first_seq;
    int          programs_before;
    reset       = 1'b1;
    addr        = '0;
    data_in     = '0;
    enable      = 1'b0;
    re          = 1'b0;
    wr          = 1'b0;
    lfsr_state  = 32'h3ae9;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    repeat (reset_cycles) @(posedge clk);
    #2;
    reset = 1'b0;

    bus_write(adc_bus_pkg::cmd_divide, 4'd0, 16'(div_a));
    for (int c = 0; c < 8; c++) begin
      bus_write(adc_bus_pkg::cmd_overflow, c[3:0], 16'(20 + 3 * c));
    end

    // ID, offset decode, busy during a frame
    bus_read(position, adc_bus_pkg::cmd_id, 4'd0, value);
    check_value("id read", 16'h0ADC, value);
    bus_read(position + 1, adc_bus_pkg::cmd_id, 4'd0, value);
    check_value("id other offset", 16'h0000, value);
    wait_cs(1'b1);
    wait_cs(1'b0);
    bus_read(position, adc_bus_pkg::cmd_busy, 4'd0, value);
    check_value("busy while cs low", 16'h0001, value);
    end_test("id_decode");

    // Write lands in the idle half right after cs rises
    value           = random_bits(15);
    first_word      = {1'b1, value[14:0]};
    programs_before = program_count;
    wait_cs(1'b0);
    wait_cs(1'b1);
    bus_write(adc_bus_pkg::cmd_program, 4'd0, first_word);
    wait_cs(1'b0);
    value = random_bits(15);
    bus_write(adc_bus_pkg::cmd_program, 4'd0, {1'b1, value[14:0]});
    while (program_count == programs_before) begin
      @(posedge clk);
    end
    check_value("program word", first_word, last_program);
    wait_frames(2);
    check_value("program count", 16'(programs_before + 1), 16'(program_count));
    end_test("program");

    // Two rounds of frames, then room for one publish
    wait_frames(18);
    repeat (64) @(posedge clk);
    for (int c = 0; c < 8; c++) begin
      bus_read(position, adc_bus_pkg::cmd_sample, c[3:0], value);
      check_value($sformatf("sample ch%0d", c), expected_frame(c[2:0]), value);
    end
    end_test("samples");

    // Read task itself spans two cycles of the gap
    bus_read(position, adc_bus_pkg::cmd_sequence, 4'(seq_chan), first_seq);
    repeat (seq_gap - 2) @(posedge clk);
    bus_read(position, adc_bus_pkg::cmd_sequence, 4'(seq_chan), value);
    check_value("sequence step", 16'(first_seq + seq_steps), value);
    end_test("sequence");

    bus_write(adc_bus_pkg::cmd_divide, 4'd0, 16'(div_b));
    wait_frames(2);
    check_value("sclk half period", 16'(div_b + 1), 16'(half_period_ns / clk_period));
    end_test("divide");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
design/adc_bus_pkg.sv
design/adc_frame_pkg.sv
design/adc_bus_regs.sv
design/adc_serial_engine.sv
design/adc_channel_hold.sv
design/adc_readback.sv
design/adc_control.sv
verification/adc_chip_model.sv
verification/adc_control_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ADC controller testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -j 0 --top-module adc_control_tb \
  -Mdir "$BUILD" -f filelist.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$BUILD/Vadc_control_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
  echo "Simulation log has no result line"
  exit 1
fi
exit 0
